//--- hdl/trdb_cpu_pkg.sv
// CPU side definitions for the trace encoder
// widths of the retirement port, decoded opcodes and privilege levels
package trdb_cpu_pkg;

    // datapath widths
    localparam int unsigned XLEN      = 32;
    localparam int unsigned CAUSE_LEN = 5;
    localparam int unsigned PRIV_LEN  = 2;
    localparam int unsigned INST_LEN  = 32;

    // major opcodes the encoder tells apart
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        // every other opcode folds into this one
        OP_OTHER  = 7'b0000000
    } opcode_e;

    // hypervisor level 2'b10 is not traced
    typedef enum logic [PRIV_LEN-1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_lvl_e;

endpackage

//--- hdl/trdb_packet_pkg.sv
// packet side definitions for the trace encoder
// packet types, branch map sizing, resync limit and payload lengths
package trdb_packet_pkg;

    // packet kinds, one per reported instruction
    typedef enum logic [2:0] {
        PKT_SYNC_START  = 3'd0,
        PKT_SYNC_TRAP   = 3'd1,
        PKT_ADDR_ONLY   = 3'd2,
        PKT_BRANCH_ADDR = 3'd3,
        PKT_BRANCH_FULL = 3'd4
    } packet_type_e;

    // branch map geometry
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned BRANCH_COUNT_LEN = 5;

    // traced steps between forced syncs
    localparam int unsigned RESYNC_MAX     = 16;
    localparam int unsigned RESYNC_CNT_LEN = $clog2(RESYNC_MAX + 1);

    // payload bus and its length field
    localparam int unsigned PAYLOAD_LEN = 80;
    localparam int unsigned P_LEN       = 7;

    // payload lengths in bits
    localparam logic [P_LEN-1:0] LEN_SYNC_START  = 7'd34;
    localparam logic [P_LEN-1:0] LEN_SYNC_TRAP   = 7'd72;
    localparam logic [P_LEN-1:0] LEN_ADDR_ONLY   = 7'd32;
    localparam logic [P_LEN-1:0] LEN_BRANCH_ADDR = 7'd68;
    localparam logic [P_LEN-1:0] LEN_BRANCH_FULL = 7'd36;

endpackage

//--- hdl/trdb_stage_pipe.sv
// instruction stage pipe, next / this / last
// shifts on each retired instruction and flags branches and jumps
`timescale 1ns/1ns

module trdb_stage_pipe import trdb_cpu_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 inst_valid_i,
    input  logic [XLEN-1:0]      pc_i,
    input  logic [INST_LEN-1:0]  inst_data_i,
    input  logic [PRIV_LEN-1:0]  priv_lvl_i,
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  logic [CAUSE_LEN-1:0] cause_i,
    input  logic [XLEN-1:0]      tval_i,
    input  logic                 trace_enable_i,
    output logic                 step_o,
    output logic                 tc_traced_o,
    output logic                 lc_traced_o,
    output logic [XLEN-1:0]      tc_pc_o,
    output priv_lvl_e            tc_priv_o,
    output priv_lvl_e            lc_priv_o,
    output logic                 lc_exception_o,
    output logic                 lc_interrupt_o,
    output logic [CAUSE_LEN-1:0] lc_cause_o,
    output logic [XLEN-1:0]      lc_tval_o,
    output logic                 lc_updiscon_o,
    output logic                 tc_branch_o,
    output logic                 tc_taken_o
);

    // control state
    logic                 nc_valid_q;
    logic                 nc_traced_q, tc_traced_q, lc_traced_q;
    logic                 nc_exc_q, tc_exc_q, lc_exc_q;
    opcode_e              nc_op_q, tc_op_q, lc_op_q;
    logic                 step_q;
    // payload, no reset
    logic [XLEN-1:0]      nc_pc_q, tc_pc_q;
    priv_lvl_e            nc_priv_q, tc_priv_q, lc_priv_q;
    logic                 nc_irq_q, tc_irq_q, lc_irq_q;
    logic [CAUSE_LEN-1:0] nc_cause_q, tc_cause_q, lc_cause_q;
    logic [XLEN-1:0]      nc_tval_q, tc_tval_q, lc_tval_q;

    // fold the opcode field into the few kinds we track
    function automatic opcode_e decode_op(input logic [INST_LEN-1:0] inst);
        case (inst[6:0])
            OP_BRANCH: return OP_BRANCH;
            OP_JALR:   return OP_JALR;
            default:   return OP_OTHER;
        endcase
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_valid_q  <= 1'b0;
            nc_traced_q <= 1'b0;
            tc_traced_q <= 1'b0;
            lc_traced_q <= 1'b0;
            nc_exc_q    <= 1'b0;
            tc_exc_q    <= 1'b0;
            lc_exc_q    <= 1'b0;
            nc_op_q     <= OP_OTHER;
            tc_op_q     <= OP_OTHER;
            lc_op_q     <= OP_OTHER;
            step_q      <= 1'b0;
        end else begin
            // tc becomes complete once nc is refilled
            step_q <= inst_valid_i & nc_valid_q;
            if (inst_valid_i) begin
                nc_valid_q  <= 1'b1;
                nc_traced_q <= trace_enable_i;
                tc_traced_q <= nc_traced_q;
                lc_traced_q <= tc_traced_q;
                nc_exc_q    <= exception_i;
                tc_exc_q    <= nc_exc_q;
                lc_exc_q    <= tc_exc_q;
                nc_op_q     <= decode_op(inst_data_i);
                tc_op_q     <= nc_op_q;
                lc_op_q     <= tc_op_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            nc_pc_q    <= pc_i;
            tc_pc_q    <= nc_pc_q;
            nc_priv_q  <= priv_lvl_e'(priv_lvl_i);
            tc_priv_q  <= nc_priv_q;
            lc_priv_q  <= tc_priv_q;
            nc_irq_q   <= interrupt_i;
            tc_irq_q   <= nc_irq_q;
            lc_irq_q   <= tc_irq_q;
            nc_cause_q <= cause_i;
            tc_cause_q <= nc_cause_q;
            lc_cause_q <= tc_cause_q;
            nc_tval_q  <= tval_i;
            tc_tval_q  <= nc_tval_q;
            lc_tval_q  <= tc_tval_q;
        end
    end

    assign step_o         = step_q;
    assign tc_traced_o    = tc_traced_q;
    assign lc_traced_o    = lc_traced_q;
    assign tc_pc_o        = tc_pc_q;
    assign tc_priv_o      = tc_priv_q;
    assign lc_priv_o      = lc_priv_q;
    assign lc_exception_o = lc_exc_q;
    assign lc_interrupt_o = lc_irq_q;
    assign lc_cause_o     = lc_cause_q;
    assign lc_tval_o      = lc_tval_q;
    // jalr target cannot be inferred from the program image
    assign lc_updiscon_o  = (lc_op_q == OP_JALR);
    assign tc_branch_o    = (tc_op_q == OP_BRANCH);
    // no compressed instructions, fall through is always pc + 4
    assign tc_taken_o     = (nc_pc_q != tc_pc_q + XLEN'(4));

endmodule

//--- hdl/trdb_branch_map.sv
// branch map, one taken bit per traced branch
// bit 0 holds the oldest branch, count tracks the filled positions
`timescale 1ns/1ns

module trdb_branch_map import trdb_packet_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        record_i,
    input  logic                        taken_i,
    input  logic                        flush_i,
    output logic [BRANCH_MAP_LEN-1:0]   map_o,
    output logic [BRANCH_COUNT_LEN-1:0] count_o,
    output logic                        full_o
);

    logic [BRANCH_MAP_LEN-1:0]   map_q;
    logic [BRANCH_COUNT_LEN-1:0] count_q;
    logic [BRANCH_MAP_LEN-1:0]   map_base;
    logic [BRANCH_COUNT_LEN-1:0] count_base;

    // flush goes first, a branch on the flushing step lands in bit 0
    assign map_base   = flush_i ? '0 : map_q;
    assign count_base = flush_i ? '0 : count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i || record_i) begin
            map_q   <= map_base;
            count_q <= count_base;
            if (record_i) begin
                // 1 means taken
                map_q[count_base] <= taken_i;
                count_q           <= count_base + 1'b1;
            end
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;
    // a full map always gets reported on the next traced step
    assign full_o  = (count_q == BRANCH_MAP_LEN);

endmodule

//--- hdl/trdb_priority.sv
// packet priority decision for each completed instruction
// also holds the resync counter that forces periodic sync packets
`timescale 1ns/1ns

module trdb_priority
    import trdb_cpu_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        step_i,
    input  logic                        tc_traced_i,
    input  logic                        lc_traced_i,
    input  priv_lvl_e                   tc_priv_i,
    input  priv_lvl_e                   lc_priv_i,
    input  logic                        lc_exception_i,
    input  logic                        lc_updiscon_i,
    input  logic                        tc_branch_i,
    input  logic [BRANCH_COUNT_LEN-1:0] map_count_i,
    input  logic                        map_full_i,
    output logic                        report_o,
    output packet_type_e                type_o,
    output logic                        flush_o,
    output logic                        record_o
);

    logic                      traced_step;
    logic                      privchange;
    logic                      resync_due;
    logic                      is_sync;
    logic [RESYNC_CNT_LEN-1:0] resync_cnt_q;

    assign traced_step = step_i & tc_traced_i;
    assign privchange  = (tc_priv_i != lc_priv_i);
    assign resync_due  = (resync_cnt_q == RESYNC_MAX);

    // first matching rule wins
    always_comb begin
        report_o = 1'b0;
        type_o   = PKT_SYNC_START;
        if (traced_step) begin
            report_o = 1'b1;
            if (lc_exception_i) begin
                // handler pc plus the trap details of lc
                type_o = PKT_SYNC_TRAP;
            end else if (!lc_traced_i || privchange || resync_due) begin
                type_o = PKT_SYNC_START;
            end else if (lc_updiscon_i && map_count_i == '0) begin
                type_o = PKT_ADDR_ONLY;
            end else if (lc_updiscon_i) begin
                type_o = PKT_BRANCH_ADDR;
            end else if (map_full_i) begin
                type_o = PKT_BRANCH_FULL;
            end else begin
                // inferable, nothing to send
                report_o = 1'b0;
            end
        end
    end

    assign is_sync  = report_o && (type_o == PKT_SYNC_START || type_o == PKT_SYNC_TRAP);
    // every packet drains the map
    assign flush_o  = report_o;
    assign record_o = traced_step & tc_branch_i;

    // counts non-sync packets since the last sync
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resync_cnt_q <= '0;
        end else if (is_sync) begin
            resync_cnt_q <= '0;
        end else if (report_o) begin
            // never passes RESYNC_MAX since reaching it forces a sync
            resync_cnt_q <= resync_cnt_q + 1'b1;
        end
    end

endmodule

//--- hdl/trdb_packet_emitter.sv
// packet emitter, packs the chosen fields into the payload
// and registers the packet so valid lasts exactly one cycle
`timescale 1ns/1ns

module trdb_packet_emitter
    import trdb_cpu_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        report_i,
    input  packet_type_e                type_i,
    input  logic [XLEN-1:0]             tc_pc_i,
    input  priv_lvl_e                   tc_priv_i,
    input  logic                        lc_interrupt_i,
    input  logic [CAUSE_LEN-1:0]        lc_cause_i,
    input  logic [XLEN-1:0]             lc_tval_i,
    input  logic [BRANCH_MAP_LEN-1:0]   map_i,
    input  logic [BRANCH_COUNT_LEN-1:0] count_i,
    output logic                        packet_valid_o,
    output packet_type_e                packet_type_o,
    output logic [P_LEN-1:0]            packet_length_o,
    output logic [PAYLOAD_LEN-1:0]      packet_payload_o
);

    logic [PAYLOAD_LEN-1:0] payload_d;
    logic [P_LEN-1:0]       length_d;

    // fields from bit 0 upward, upper bits stay zero
    // map and count are still the pre-flush values here
    always_comb begin
        payload_d = '0;
        length_d  = '0;
        case (type_i)
            PKT_SYNC_START: begin
                payload_d = PAYLOAD_LEN'({tc_pc_i, tc_priv_i});
                length_d  = LEN_SYNC_START;
            end
            PKT_SYNC_TRAP: begin
                payload_d = PAYLOAD_LEN'({lc_tval_i, lc_cause_i, lc_interrupt_i,
                                          tc_pc_i, tc_priv_i});
                length_d  = LEN_SYNC_TRAP;
            end
            PKT_ADDR_ONLY: begin
                payload_d = PAYLOAD_LEN'(tc_pc_i);
                length_d  = LEN_ADDR_ONLY;
            end
            PKT_BRANCH_ADDR: begin
                payload_d = PAYLOAD_LEN'({tc_pc_i, map_i, count_i});
                length_d  = LEN_BRANCH_ADDR;
            end
            PKT_BRANCH_FULL: begin
                payload_d = PAYLOAD_LEN'({map_i, count_i});
                length_d  = LEN_BRANCH_FULL;
            end
            default: begin
                payload_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= report_i;
        end
    end

    // packet fields only load on a report
    always_ff @(posedge clk_i) begin
        if (report_i) begin
            packet_type_o    <= type_i;
            packet_length_o  <= length_d;
            packet_payload_o <= payload_d;
        end
    end

endmodule

//--- hdl/trace_debugger.sv
// trace encoder top level
// stage pipe feeds priority and branch map, emitter drives the packet port
`timescale 1ns/1ns

module trace_debugger
    import trdb_cpu_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   inst_valid_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [INST_LEN-1:0]    inst_data_i,
    input  logic [PRIV_LEN-1:0]    priv_lvl_i,
    input  logic                   exception_i,
    input  logic                   interrupt_i,
    input  logic [CAUSE_LEN-1:0]   cause_i,
    input  logic [XLEN-1:0]        tval_i,
    input  logic                   trace_enable_i,
    output logic                   packet_valid_o,
    output packet_type_e           packet_type_o,
    output logic [P_LEN-1:0]       packet_length_o,
    output logic [PAYLOAD_LEN-1:0] packet_payload_o
);

    // pipe outputs
    logic                        step;
    logic                        tc_traced, lc_traced;
    logic [XLEN-1:0]             tc_pc;
    priv_lvl_e                   tc_priv, lc_priv;
    logic                        lc_exception, lc_interrupt;
    logic [CAUSE_LEN-1:0]        lc_cause;
    logic [XLEN-1:0]             lc_tval;
    logic                        lc_updiscon;
    logic                        tc_branch, tc_taken;
    // decision and map
    logic                        report, flush, record;
    packet_type_e                pkt_type;
    logic [BRANCH_MAP_LEN-1:0]   branch_map;
    logic [BRANCH_COUNT_LEN-1:0] branch_count;
    logic                        map_full;

    trdb_stage_pipe i_stage_pipe (
        .clk_i(clk_i), .rst_ni(rst_ni), .inst_valid_i(inst_valid_i), .pc_i(pc_i),
        .inst_data_i(inst_data_i), .priv_lvl_i(priv_lvl_i), .exception_i(exception_i),
        .interrupt_i(interrupt_i), .cause_i(cause_i), .tval_i(tval_i),
        .trace_enable_i(trace_enable_i), .step_o(step), .tc_traced_o(tc_traced),
        .lc_traced_o(lc_traced), .tc_pc_o(tc_pc), .tc_priv_o(tc_priv), .lc_priv_o(lc_priv),
        .lc_exception_o(lc_exception), .lc_interrupt_o(lc_interrupt), .lc_cause_o(lc_cause),
        .lc_tval_o(lc_tval), .lc_updiscon_o(lc_updiscon), .tc_branch_o(tc_branch),
        .tc_taken_o(tc_taken)
    );

    trdb_priority i_priority (
        .clk_i(clk_i), .rst_ni(rst_ni), .step_i(step), .tc_traced_i(tc_traced),
        .lc_traced_i(lc_traced), .tc_priv_i(tc_priv), .lc_priv_i(lc_priv),
        .lc_exception_i(lc_exception), .lc_updiscon_i(lc_updiscon), .tc_branch_i(tc_branch),
        .map_count_i(branch_count), .map_full_i(map_full), .report_o(report),
        .type_o(pkt_type), .flush_o(flush), .record_o(record)
    );

    trdb_branch_map i_branch_map (
        .clk_i(clk_i), .rst_ni(rst_ni), .record_i(record), .taken_i(tc_taken),
        .flush_i(flush), .map_o(branch_map), .count_o(branch_count), .full_o(map_full)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i(clk_i), .rst_ni(rst_ni), .report_i(report), .type_i(pkt_type),
        .tc_pc_i(tc_pc), .tc_priv_i(tc_priv), .lc_interrupt_i(lc_interrupt),
        .lc_cause_i(lc_cause), .lc_tval_i(lc_tval), .map_i(branch_map),
        .count_i(branch_count), .packet_valid_o(packet_valid_o),
        .packet_type_o(packet_type_o), .packet_length_o(packet_length_o),
        .packet_payload_o(packet_payload_o)
    );

endmodule

//--- tb/tb_clock_gen.sv
// testbench clock and reset source
// 100 ns clock, active low reset held for the first 3 cycles
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (3) @(posedge clk_o);
        // release away from the sampling edge
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- tb/trace_debugger_sva.sv
// assertions on the trace encoder packet port
// bound into the top level, watches the packet strobe and length field
`timescale 1ns/1ns

module trace_debugger_sva
    import trdb_packet_pkg::*;
(
    input logic             clk_i,
    input logic             rst_ni,
    input logic             step_i,
    input logic             packet_valid_i,
    input packet_type_e     packet_type_i,
    input logic [P_LEN-1:0] packet_length_i
);

    logic [P_LEN-1:0] len_exp;

    // payload length each packet type must carry
    always_comb begin
        case (packet_type_i)
            PKT_SYNC_START:  len_exp = LEN_SYNC_START;
            PKT_SYNC_TRAP:   len_exp = LEN_SYNC_TRAP;
            PKT_ADDR_ONLY:   len_exp = LEN_ADDR_ONLY;
            PKT_BRANCH_ADDR: len_exp = LEN_BRANCH_ADDR;
            PKT_BRANCH_FULL: len_exp = LEN_BRANCH_FULL;
            default:         len_exp = '0;
        endcase
    end

    // one cycle pulse unless another step follows right away
    pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i && !step_i |=> !packet_valid_i)
        else $error("packet_valid_o held longer than one cycle");

    length_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        packet_valid_i |-> packet_length_i == len_exp)
        else $error("packet_length_o does not fit packet_type_o");

    reset_a: assert property (@(posedge clk_i) !rst_ni |-> !packet_valid_i)
        else $error("packet_valid_o high during reset");

endmodule

bind trace_debugger trace_debugger_sva i_sva (
    .clk_i(clk_i), .rst_ni(rst_ni), .step_i(step), .packet_valid_i(packet_valid_o),
    .packet_type_i(packet_type_o), .packet_length_i(packet_length_o)
);

//--- tb/trace_debugger_tb.sv
// testbench for the trace encoder top level
// random retirement stream, reference model of the packet rules, packet monitor
`timescale 1ns/1ns

module trace_debugger_tb
    import trdb_cpu_pkg::*;
    import trdb_packet_pkg::*;
();

    localparam logic [XLEN-1:0] BOOT_PC    = 32'h8000_0000;
    localparam logic [XLEN-1:0] HANDLER_PC = 32'h8000_0100;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int RESET_TIMEOUT = 10;
    // instruction kinds of the generated program
    localparam int K_SEQ    = 0;
    localparam int K_BRANCH = 1;
    localparam int K_JALR   = 2;
    localparam int K_TRAP   = 3;

    typedef struct packed {
        logic [XLEN-1:0]      pc;
        logic [INST_LEN-1:0]  inst;
        logic [PRIV_LEN-1:0]  priv;
        logic                 exc;
        logic                 irq;
        logic [CAUSE_LEN-1:0] cause;
        logic [XLEN-1:0]      tval;
        logic                 en;
    } inst_t;

    typedef struct packed {
        logic                   report;
        logic [2:0]             ptype;
        logic [P_LEN-1:0]       len;
        logic [PAYLOAD_LEN-1:0] payload;
    } pkt_t;

    logic clk, rst_n, inst_valid, exception, interrupt, trace_en;
    logic [XLEN-1:0] pc, tval;
    logic [INST_LEN-1:0] inst_data;
    logic [PRIV_LEN-1:0] priv_lvl;
    logic [CAUSE_LEN-1:0] cause;
    logic packet_valid;
    packet_type_e packet_type;
    logic [P_LEN-1:0] packet_length;
    logic [PAYLOAD_LEN-1:0] packet_payload;

    // model state, tc and lc mirror the encoder stages
    inst_t m_tc = '0;
    inst_t m_lc = '0;
    logic m_have_tc = 1'b0;
    logic [BRANCH_MAP_LEN-1:0] m_map = '0;
    int m_count = 0;
    int m_resync = 0;
    pkt_t exp_q[$];
    pkt_t mon_exp;
    // program generator state
    logic [XLEN-1:0] cur_pc = BOOT_PC;
    logic [PRIV_LEN-1:0] cur_priv = PRIV_M;
    logic cur_en = 1'b1;
    int errors = 0;
    int err_base = 0;
    int n_tests = 0;
    int n_failed = 0;
    int n_pkts = 0;
    int pkt_base = 0;

    tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

    trace_debugger UUT (
        .clk_i(clk), .rst_ni(rst_n), .inst_valid_i(inst_valid), .pc_i(pc),
        .inst_data_i(inst_data), .priv_lvl_i(priv_lvl), .exception_i(exception),
        .interrupt_i(interrupt), .cause_i(cause), .tval_i(tval), .trace_enable_i(trace_en),
        .packet_valid_o(packet_valid), .packet_type_o(packet_type),
        .packet_length_o(packet_length), .packet_payload_o(packet_payload)
    );

    // expected packet for a completed tc, given lc and the map before the flush
    function automatic pkt_t ref_packet(input inst_t tc, input inst_t lc,
                                        input logic [BRANCH_MAP_LEN-1:0] map,
                                        input int count, input int resync);
        pkt_t p;
        logic updiscon;
        p = '0;
        updiscon = (lc.inst[6:0] == OP_JALR);
        if (!tc.en) return p;
        p.report = 1'b1;
        if (lc.exc) begin
            p.ptype   = PKT_SYNC_TRAP;
            p.len     = LEN_SYNC_TRAP;
            p.payload = PAYLOAD_LEN'({lc.tval, lc.cause, lc.irq, tc.pc, tc.priv});
        end else if (!lc.en || tc.priv != lc.priv || resync == RESYNC_MAX) begin
            p.ptype   = PKT_SYNC_START;
            p.len     = LEN_SYNC_START;
            p.payload = PAYLOAD_LEN'({tc.pc, tc.priv});
        end else if (updiscon && count == 0) begin
            p.ptype   = PKT_ADDR_ONLY;
            p.len     = LEN_ADDR_ONLY;
            p.payload = PAYLOAD_LEN'(tc.pc);
        end else if (updiscon) begin
            p.ptype   = PKT_BRANCH_ADDR;
            p.len     = LEN_BRANCH_ADDR;
            p.payload = PAYLOAD_LEN'({tc.pc, map, BRANCH_COUNT_LEN'(count)});
        end else if (count == BRANCH_MAP_LEN) begin
            p.ptype   = PKT_BRANCH_FULL;
            p.len     = LEN_BRANCH_FULL;
            p.payload = PAYLOAD_LEN'({map, BRANCH_COUNT_LEN'(count)});
        end else begin
            p.report = 1'b0;
        end
        return p;
    endfunction

    // new nc completes tc, then the model stages shift
    task automatic model_accept(input inst_t nc);
        pkt_t p;
        if (m_have_tc) begin
            p = ref_packet(m_tc, m_lc, m_map, m_count, m_resync);
            if (p.report) begin
                exp_q.push_back(p);
                m_map   = '0;
                m_count = 0;
            end
            if (m_tc.en) begin
                // sync packets restart the count, other packets add one
                if (p.report && (p.ptype == PKT_SYNC_START || p.ptype == PKT_SYNC_TRAP))
                    m_resync = 0;
                else if (p.report)
                    m_resync++;
                // taken when the successor is not the fall through address
                if (m_tc.inst[6:0] == OP_BRANCH) begin
                    m_map[m_count] = (nc.pc != m_tc.pc + 4);
                    m_count++;
                end
            end
        end
        m_lc      = m_tc;
        m_tc      = nc;
        m_have_tc = 1'b1;
    endtask

    task automatic check_value(input string name, input logic [PAYLOAD_LEN-1:0] exp_v,
                               input logic [PAYLOAD_LEN-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    // called on a falling edge, returns on one
    task automatic drive_inst(input inst_t r, input int gap);
        inst_valid = 1'b1;
        pc         = r.pc;
        inst_data  = r.inst;
        priv_lvl   = r.priv;
        exception  = r.exc;
        interrupt  = r.irq;
        cause      = r.cause;
        tval       = r.tval;
        trace_en   = r.en;
        model_accept(r);
        @(negedge clk);
        inst_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    // build one instruction at cur_pc and move cur_pc to its successor
    task automatic issue(input int kind, input int gap);
        inst_t r;
        logic [XLEN-1:0] off;
        r      = '0;
        r.pc   = cur_pc;
        r.priv = cur_priv;
        r.en   = cur_en;
        r.inst = $urandom;
        case (kind)
            K_BRANCH: begin
                r.inst[6:0] = OP_BRANCH;
                off = XLEN'($urandom_range(2, 64)) << 2;
                if ($urandom_range(0, 1) == 0)
                    cur_pc = cur_pc + 4;
                else if ($urandom_range(0, 1) == 0)
                    cur_pc = cur_pc + off;
                else
                    cur_pc = cur_pc - off;
            end
            K_JALR: begin
                r.inst[6:0] = OP_JALR;
                cur_pc = XLEN'($urandom) & ~32'h3;
            end
            K_TRAP: begin
                // ecall word, trap info selected by the cpu
                r.inst  = 32'h0000_0073;
                r.exc   = 1'b1;
                r.irq   = 1'($urandom_range(0, 1));
                r.cause = CAUSE_LEN'($urandom);
                r.tval  = $urandom;
                cur_pc  = HANDLER_PC;
            end
            default: begin
                r.inst[6:0] = 7'b0010011;
                cur_pc = cur_pc + 4;
            end
        endcase
        drive_inst(r, gap);
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected packets never came out", exp_q.size());
            errors++;
            exp_q.delete();
        end
        n_tests++;
        if (errors != err_base)
            n_failed++;
        $display("test %0d %s: %s, %0d packets checked", n_tests, name,
                 (errors == err_base) ? "ok" : "FAILED", n_pkts - pkt_base);
        err_base = errors;
        pkt_base = n_pkts;
    endtask

    task automatic run_tests();
        int i;
        int roll;
        int kind;
        repeat (3) issue(K_SEQ, 1);
        cur_en = 1'b0;
        repeat (3) issue(K_SEQ, 1);
        cur_en = 1'b1;
        repeat (3) issue(K_SEQ, 0);
        finish_test("sync start after reset and re-enable");
        issue(K_SEQ, 1);
        issue(K_TRAP, 1);
        issue(K_SEQ, 0);
        issue(K_SEQ, 2);
        finish_test("sync trap after exception");
        issue(K_JALR, 1);
        repeat (2) issue(K_SEQ, 1);
        repeat (2) issue(K_BRANCH, 0);
        issue(K_JALR, 1);
        repeat (2) issue(K_SEQ, 1);
        finish_test("jalr with and without pending branches");
        repeat (31) issue(K_BRANCH, 0);
        issue(K_JALR, 1);
        repeat (2) issue(K_SEQ, 1);
        finish_test("run of 31 branches");
        // each jalr and its successor give one address-only packet
        repeat (18) begin
            issue(K_JALR, 0);
            issue(K_SEQ, 0);
        end
        cur_priv = PRIV_U;
        repeat (3) issue(K_SEQ, 1);
        cur_priv = PRIV_M;
        repeat (2) issue(K_SEQ, 1);
        finish_test("resync limit and privilege change");
        for (i = 0; i < 2000; i++) begin
            roll = $urandom_range(0, 99);
            if (roll < 2)
                cur_en = ~cur_en;
            if (roll >= 95)
                cur_priv = (cur_priv == PRIV_M) ? PRIV_S : PRIV_M;
            kind = (roll < 50) ? K_SEQ : (roll < 78) ? K_BRANCH :
                   (roll < 88) ? K_JALR : (roll < 95) ? K_TRAP : K_SEQ;
            issue(kind, $urandom_range(0, 2));
        end
        finish_test("random mixed run");
    endtask

    // packet outputs settle after the rising edge, sample them on the falling one
    always @(negedge clk) begin
        if (rst_n === 1'b1 && packet_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("unexpected packet of type %0d while none was due", packet_type);
                errors++;
            end else begin
                mon_exp = exp_q.pop_front();
                check_value("packet_type_o", PAYLOAD_LEN'(mon_exp.ptype),
                            PAYLOAD_LEN'(packet_type));
                check_value("packet_length_o", PAYLOAD_LEN'(mon_exp.len),
                            PAYLOAD_LEN'(packet_length));
                check_value("packet_payload_o", mon_exp.payload, packet_payload);
                n_pkts++;
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(32'h9ffe));
        inst_valid = 1'b0;
        pc         = '0;
        inst_data  = '0;
        priv_lvl   = PRIV_M;
        exception  = 1'b0;
        interrupt  = 1'b0;
        cause      = '0;
        tval       = '0;
        trace_en   = 1'b0;
        waited     = 0;
        @(negedge clk);
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n === 1'b1) begin
            @(negedge clk);
            run_tests();
        end else begin
            $display("reset was never released");
            errors++;
        end
        $display("tests %0d, failed %0d, packets checked %0d, errors %0d",
                 n_tests, n_failed, n_pkts, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- compile.f
hdl/trdb_cpu_pkg.sv
hdl/trdb_packet_pkg.sv
hdl/trdb_stage_pipe.sv
hdl/trdb_branch_map.sv
hdl/trdb_priority.sv
hdl/trdb_packet_emitter.sv
hdl/trace_debugger.sv
tb/tb_clock_gen.sv
tb/trace_debugger_sva.sv
tb/trace_debugger_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the trace encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module trace_debugger_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtrace_debugger_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
